/* rtl/am4_alu.sv */
/*
   am4 ALU
   eight functions over R/S, word or byte NZVC selection, and the
   registered Y output and status register
*/
`timescale 1ns/100ps

module am4_alu
   import am4_pkg::*;
#(
   parameter int data_w = 16
)
(
   input  logic              pin_clk,   // slice clock
   input  logic              dclo,      // async reset, active high
   input  logic              stb_i,     // execute strobe
   input  micro_t            mi_i,      // microinstruction
   input  logic [data_w-1:0] r_i,       // R operand
   input  logic [data_w-1:0] s_i,       // S operand
   input  logic [data_w-1:0] a_i,       // register A for RAMA
   output logic [data_w-1:0] f_o,       // function result, combinational
   output logic [data_w-1:0] y_o,       // registered Y
   output alu_flags_t        psw_o      // registered NZVC
);

localparam int hw = data_w / 2;         // byte boundary

logic [data_w-1:0] op_x;                // adder left input
logic [data_w-1:0] op_y;                // adder right input
logic [data_w:0]   sum;                 // one extra bit for carry out
logic              arith;               // function uses the adder

logic              c_top;               // carry out of the word, c16
logic              c_msb;               // carry into word MSB
logic              c_mid;               // carry out of low half, c8
logic              c_hmsb;              // carry into low half MSB

alu_flags_t        flags;               // flags of this cycle
logic [data_w-1:0] y_d;                 // next Y

// operand inversion for the two subtract forms
always_comb
begin
   op_x  = r_i;
   op_y  = s_i;
   arith = 1'b1;
   case (mi_i.fn)
      ADD:     arith = 1'b1;
      SUBR:    op_x  = ~r_i;            // S - R
      SUBS:    op_y  = ~s_i;            // R - S
      default: arith = 1'b0;            // logic group
   endcase
end

assign sum = {1'b0, op_x} + {1'b0, op_y} + {{data_w{1'b0}}, mi_i.cin};

// internal carries recovered from sum and inputs, no second adder
assign c_top  = sum[data_w];
assign c_msb  = sum[data_w-1] ^ op_x[data_w-1] ^ op_y[data_w-1];
assign c_mid  = sum[hw] ^ op_x[hw] ^ op_y[hw];
assign c_hmsb = sum[hw-1] ^ op_x[hw-1] ^ op_y[hw-1];

always_comb
begin
   case (mi_i.fn)
      ADD, SUBR, SUBS: f_o = sum[data_w-1:0];
      OR:      f_o = r_i | s_i;
      AND:     f_o = r_i & s_i;
      NOTRS:   f_o = ~r_i & s_i;
      EXOR:    f_o = r_i ^ s_i;
      EXNOR:   f_o = ~(r_i ^ s_i);
      default: f_o = sum[data_w-1:0];
   endcase
end

// word flags at the top bit, byte flags at the middle, both from F
always_comb
begin
   if (mi_i.byte_mode)
   begin
      flags.n = f_o[hw-1];              // f7
      flags.z = (f_o[hw-1:0] == '0);    // zl
      flags.c = arith & c_mid;          // c8
      flags.v = arith & (c_hmsb ^ c_mid); // v8
   end
   else
   begin
      flags.n = f_o[data_w-1];          // f15
      flags.z = (f_o == '0);
      flags.c = arith & c_top;          // c16
      flags.v = arith & (c_msb ^ c_top); // v16
   end
end

assign y_d = (mi_i.dst == RAMA) ? a_i : f_o; // A bypass on RAMA only

always_ff @(posedge pin_clk or posedge dclo)
begin
   if (dclo)
   begin
      y_o   <= '0;
      psw_o <= '0;
   end
   else
      if (stb_i)
      begin
         y_o <= y_d;
         if (mi_i.psw_we)
            psw_o <= flags;             // status held otherwise
      end
end

endmodule

/* rtl/am4_pkg.sv */
/*
   am4 slice shared types
   ALU operand, function and destination codes, the microinstruction word
   and the NZVC status flags
*/
package am4_pkg;

   // operand pairs (R,S) fed to the ALU
   typedef enum logic [2:0]
   {
      AQ = 3'd0,           // R=A, S=Q
      AB = 3'd1,           // R=A, S=B
      ZQ = 3'd2,           // R=0, S=Q
      ZB = 3'd3,           // R=0, S=B
      ZA = 3'd4,           // R=0, S=A
      DA = 3'd5,           // R=D, S=A
      DQ = 3'd6,           // R=D, S=Q
      DZ = 3'd7            // R=D, S=0
   } alu_src_e;

   typedef enum logic [2:0]
   {
      ADD   = 3'd0,        // R + S + cin
      SUBR  = 3'd1,        // S + ~R + cin
      SUBS  = 3'd2,        // R + ~S + cin
      OR    = 3'd3,        // R | S
      AND   = 3'd4,        // R & S
      NOTRS = 3'd5,        // ~R & S
      EXOR  = 3'd6,        // R ^ S
      EXNOR = 3'd7         // ~(R ^ S)
   } alu_fn_e;

   // destination codes, same order as the 2901 I[8:6] field
   typedef enum logic [2:0]
   {
      QREG  = 3'd0,        // F -> Q, Y = F
      NOP   = 3'd1,        // no write, Y = F
      RAMA  = 3'd2,        // F -> B, Y = A
      RAMF  = 3'd3,        // F -> B, Y = F
      RAMQD = 3'd4,        // F/2 -> B, Q/2 -> Q
      RAMD  = 3'd5,        // F/2 -> B
      RAMQU = 3'd6,        // 2F -> B, 2Q -> Q
      RAMU  = 3'd7         // 2F -> B
   } alu_dst_e;

   typedef struct packed
   {
      alu_src_e   src;     // operand pair
      alu_fn_e    fn;      // ALU function
      alu_dst_e   dst;     // write target and Y source
      logic [3:0] a;       // A port address
      logic [3:0] b;       // B port address, also write address
      logic       cin;     // carry in
      logic       sh_in;   // fill bit at vacated end of any shift
      logic       byte_mode; // flags from the low half
      logic       psw_we;  // status register write enable
   } micro_t;

   typedef struct packed
   {
      logic n;             // negative
      logic z;             // zero
      logic v;             // overflow
      logic c;             // carry
   } alu_flags_t;

endpackage

/* rtl/am4_regfile.sv */
/*
   am4 register file
   sixteen general registers plus Q, forms the R/S operand pair and
   writes back F, shifted F and shifted Q on a strobed edge
*/
`timescale 1ns/100ps

module am4_regfile
   import am4_pkg::*;
#(
   parameter int data_w = 16
)
(
   input  logic              pin_clk,   // slice clock
   input  logic              dclo,      // async reset, active high
   input  logic              stb_i,     // execute strobe
   input  micro_t            mi_i,      // microinstruction
   input  logic [data_w-1:0] d_i,       // external data
   input  logic [data_w-1:0] f_i,       // ALU result for write-back
   output logic [data_w-1:0] r_o,       // R operand
   output logic [data_w-1:0] s_o,       // S operand
   output logic [data_w-1:0] a_o        // register A, for RAMA on Y
);

logic [data_w-1:0] ram [16];            // general registers
logic [data_w-1:0] q_reg;               // Q register
logic [data_w-1:0] b_rd;                // register B read

logic [data_w-1:0] f_dn;                // F shifted toward LSB
logic [data_w-1:0] f_up;                // F shifted toward MSB
logic [data_w-1:0] q_dn;                // Q shifted toward LSB
logic [data_w-1:0] q_up;                // Q shifted toward MSB

logic              ram_we;              // write B this cycle
logic [data_w-1:0] ram_d;               // data into B
logic              q_we;                // write Q this cycle
logic [data_w-1:0] q_d;                 // data into Q

// both ports read asynchronously, like the 2901 latches when clock high
assign a_o  = ram[mi_i.a];
assign b_rd = ram[mi_i.b];

// sh_in enters at whichever end is vacated
assign f_dn = {mi_i.sh_in, f_i[data_w-1:1]};
assign f_up = {f_i[data_w-2:0], mi_i.sh_in};
assign q_dn = {mi_i.sh_in, q_reg[data_w-1:1]};
assign q_up = {q_reg[data_w-2:0], mi_i.sh_in};

always_comb
begin
   case (mi_i.src)
      AQ, AB:     r_o = a_o;            // A on R
      ZQ, ZB, ZA: r_o = '0;             // zero on R
      DA, DQ, DZ: r_o = d_i;            // external data on R
      default:    r_o = '0;
   endcase

   case (mi_i.src)
      AQ, ZQ, DQ: s_o = q_reg;          // Q on S
      AB, ZB:     s_o = b_rd;           // B on S
      ZA, DA:     s_o = a_o;            // A on S
      DZ:         s_o = '0;             // zero on S
      default:    s_o = '0;
   endcase
end

// destination decode, only write targets here
always_comb
begin
   ram_we = 1'b1;
   ram_d  = f_i;
   q_we   = 1'b0;
   q_d    = q_reg;
   case (mi_i.dst)
      QREG:
      begin
         ram_we = 1'b0;                 // F goes to Q only
         q_we   = 1'b1;
         q_d    = f_i;
      end
      NOP:
         ram_we = 1'b0;                 // nothing stored
      RAMA, RAMF:
         ram_d  = f_i;                  // plain F into B
      RAMQD:
      begin
         ram_d  = f_dn;                 // down shift of F and Q together
         q_we   = 1'b1;
         q_d    = q_dn;
      end
      RAMD:
         ram_d  = f_dn;
      RAMQU:
      begin
         ram_d  = f_up;                 // up shift of F and Q together
         q_we   = 1'b1;
         q_d    = q_up;
      end
      RAMU:
         ram_d  = f_up;
      default:
         ram_we = 1'b0;
   endcase
end

always_ff @(posedge pin_clk or posedge dclo)
begin
   if (dclo)
   begin
      for (int i = 0; i < 16; i++)
         ram[i] <= '0;                  // whole file cleared on reset
      q_reg <= '0;
   end
   else
      if (stb_i)
      begin
         if (ram_we)
            ram[mi_i.b] <= ram_d;       // write-back into B
         if (q_we)
            q_reg <= q_d;
      end
end

endmodule

/* rtl/am4_slice.sv */
/*
   am4 slice top
   register file and ALU joined into one data_w wide datapath
*/
`timescale 1ns/100ps

module am4_slice
   import am4_pkg::*;
#(
   parameter int data_w = 16            // must be even
)
(
   input  logic              pin_clk,   // slice clock
   input  logic              dclo,      // async reset, active high
   input  logic              stb_i,     // one microinstruction per high edge
   input  micro_t            mi_i,      // microinstruction
   input  logic [data_w-1:0] d_i,       // external data
   output logic [data_w-1:0] y_o,       // Y output
   output alu_flags_t        psw_o      // NZVC status
);

logic [data_w-1:0] r_op;                // R operand
logic [data_w-1:0] s_op;                // S operand
logic [data_w-1:0] a_rd;                // register A
logic [data_w-1:0] f_res;               // ALU result back to file

am4_regfile #(
   .data_w  (data_w)
) regfile_inst
(
   .pin_clk (pin_clk),
   .dclo    (dclo),
   .stb_i   (stb_i),
   .mi_i    (mi_i),
   .d_i     (d_i),
   .f_i     (f_res),                    // write-back path
   .r_o     (r_op),
   .s_o     (s_op),
   .a_o     (a_rd)
);

am4_alu #(
   .data_w  (data_w)
) alu_inst
(
   .pin_clk (pin_clk),
   .dclo    (dclo),
   .stb_i   (stb_i),
   .mi_i    (mi_i),
   .r_i     (r_op),
   .s_i     (s_op),
   .a_i     (a_rd),                     // for Y on RAMA
   .f_o     (f_res),
   .y_o     (y_o),
   .psw_o   (psw_o)
);

endmodule

/* run.sh */
#!/bin/sh
# build and run the am4 slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_am4_slice

verilator --binary --timing --assert -f verilog.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

/* verif/am4_slice_sva.sv */
/*
   am4 ALU assertions
   status hold, clearing on reset and a known Y, bound into am4_alu
*/
`timescale 1ns/100ps

module am4_slice_sva
   import am4_pkg::*;
#(
   parameter int data_w = 16
)
(
   input logic              pin_clk,
   input logic              dclo,
   input logic              stb_i,
   input micro_t            mi_i,
   input logic [data_w-1:0] y_o,
   input alu_flags_t        psw_o
);

// status moves only on a strobed edge with psw_we set
psw_hold_a: assert property (@(posedge pin_clk) disable iff (dclo)
   (!stb_i || !mi_i.psw_we) |=> $stable(psw_o))
   else $error("psw_o changed without a strobed status write");

reset_clear_a: assert property (@(posedge pin_clk)
   dclo |=> (y_o == '0) && (psw_o == '0))
   else $error("y_o or psw_o not cleared by dclo");

y_known_a: assert property (@(posedge pin_clk) disable iff (dclo)
   !$isunknown(y_o))
   else $error("y_o holds unknown bits");

endmodule

bind am4_alu am4_slice_sva #(.data_w(data_w)) alu_sva_inst
(
   .pin_clk (pin_clk),
   .dclo    (dclo),
   .stb_i   (stb_i),
   .mi_i    (mi_i),
   .y_o     (y_o),
   .psw_o   (psw_o)
);

/* verif/tb_am4_slice.sv */
/*
   testbench for the am4 slice
   random microinstructions checked against a behavioral model of the
   register file, ALU, Y register and NZVC status
*/
`timescale 1ns/100ps

module tb_am4_slice
   import am4_pkg::*;
();

localparam int dw         = 16;
localparam int hw         = dw / 2;
localparam int clk_period = 8;
localparam int n_hold     = 10;
localparam int n_arith    = 200;
localparam int n_byte     = 200;
localparam int n_rand     = 2000;
// every op is one clock, loads and read-backs included
localparam int total_ops  = 32 + n_hold + 3 * n_arith + 4 * 64 + 6 * 64 + 3 * n_byte + n_rand;

logic          pin_clk;
logic          dclo;
logic          stb_i;
micro_t        mi_i;
logic [dw-1:0] d_i;
logic [dw-1:0] y_o;
alu_flags_t    psw_o;

integer        seed;
int            checks;
int            errors;
int            t_checks;              // per test
int            t_errors;

logic [dw-1:0] m_regs [16];           // model register file
logic [dw-1:0] m_q;                   // model Q
logic [dw-1:0] m_y;                   // model Y
alu_flags_t    m_psw;                 // model status

am4_slice #(
   .data_w  (dw)
) am4_slice_inst
(
   .pin_clk (pin_clk),
   .dclo    (dclo),
   .stb_i   (stb_i),
   .mi_i    (mi_i),
   .d_i     (d_i),
   .y_o     (y_o),
   .psw_o   (psw_o)
);

initial pin_clk = 1'b0;
always #(clk_period / 2) pin_clk = ~pin_clk;

function automatic logic [31:0] rand32();
   return $random(seed);
endfunction

function automatic logic [dw-1:0] rand_word();
   logic [31:0] rnd;
   rnd = $random(seed);
   return rnd[dw-1:0];
endfunction

function automatic micro_t rand_micro();
   logic [31:0] rnd;
   rnd = $random(seed);
   return micro_t'(rnd[$bits(micro_t)-1:0]);  // every field random
endfunction

function automatic micro_t make_micro(alu_src_e src, alu_fn_e fn, alu_dst_e dst);
   micro_t mi;
   mi     = '0;
   mi.src = src;
   mi.fn  = fn;
   mi.dst = dst;
   return mi;
endfunction

// one strobed microinstruction applied to the model state
function automatic void model_step(micro_t mi, logic [dw-1:0] d);
   logic [dw-1:0] a_v;
   logic [dw-1:0] b_v;
   logic [dw-1:0] r;
   logic [dw-1:0] s;
   logic [dw-1:0] x;
   logic [dw-1:0] y;
   logic [dw-1:0] f;
   logic [dw:0]   sum;
   logic [hw:0]   lsum;
   logic          arith;
   alu_flags_t    fl;
   a_v = m_regs[mi.a];
   b_v = m_regs[mi.b];
   case (mi.src)
      AQ, AB:     r = a_v;
      DA, DQ, DZ: r = d;
      default:    r = '0;             // ZQ, ZB, ZA
   endcase
   case (mi.src)
      AQ, ZQ, DQ: s = m_q;
      AB, ZB:     s = b_v;
      ZA, DA:     s = a_v;
      default:    s = '0;             // DZ
   endcase
   arith = (mi.fn == ADD) || (mi.fn == SUBR) || (mi.fn == SUBS);
   x = (mi.fn == SUBR) ? s : r;       // S - R as S + ~R + cin
   y = (mi.fn == SUBR) ? ~r : ((mi.fn == SUBS) ? ~s : s);
   sum  = {1'b0, x} + {1'b0, y} + {{dw{1'b0}}, mi.cin};
   lsum = {1'b0, x[hw-1:0]} + {1'b0, y[hw-1:0]} + {{hw{1'b0}}, mi.cin};
   case (mi.fn)
      OR:      f = r | s;
      AND:     f = r & s;
      NOTRS:   f = ~r & s;
      EXOR:    f = r ^ s;
      EXNOR:   f = ~(r ^ s);
      default: f = sum[dw-1:0];
   endcase
   // overflow from operand signs, same result as the carry rule
   if (mi.byte_mode)
   begin
      fl.n = f[hw-1];
      fl.z = (f[hw-1:0] == '0);
      fl.c = arith & lsum[hw];
      fl.v = arith & (x[hw-1] == y[hw-1]) & (f[hw-1] != x[hw-1]);
   end
   else
   begin
      fl.n = f[dw-1];
      fl.z = (f == '0);
      fl.c = arith & sum[dw];
      fl.v = arith & (x[dw-1] == y[dw-1]) & (f[dw-1] != x[dw-1]);
   end
   m_y = (mi.dst == RAMA) ? a_v : f;
   if (mi.psw_we)
      m_psw = fl;
   case (mi.dst)
      QREG:       m_q = f;
      RAMA, RAMF: m_regs[mi.b] = f;
      RAMQD:
      begin
         m_regs[mi.b] = {mi.sh_in, f[dw-1:1]};
         m_q          = {mi.sh_in, m_q[dw-1:1]};
      end
      RAMD:       m_regs[mi.b] = {mi.sh_in, f[dw-1:1]};
      RAMQU:
      begin
         m_regs[mi.b] = {f[dw-2:0], mi.sh_in};
         m_q          = {m_q[dw-2:0], mi.sh_in};
      end
      RAMU:       m_regs[mi.b] = {f[dw-2:0], mi.sh_in};
      default:    ;                   // NOP writes nothing
   endcase
endfunction

task automatic compare_outputs();
   checks   = checks + 2;
   t_checks = t_checks + 2;
   if (y_o !== m_y)
   begin
      errors++;
      t_errors++;
      $display("Fail at %0t ns: y_o expected %h actual %h", $time, m_y, y_o);
   end
   if (psw_o !== m_psw)
   begin
      errors++;
      t_errors++;
      $display("Fail at %0t ns: psw_o expected %b actual %b", $time, m_psw, psw_o);
   end
endtask

// drive on the falling edge, check just after the rising edge
task automatic do_op(input micro_t mi, input logic [dw-1:0] d, input logic stb);
   @(negedge pin_clk);
   stb_i = stb;
   mi_i  = mi;
   d_i   = d;
   if (stb)
      model_step(mi, d);
   @(posedge pin_clk);
   #2;
   compare_outputs();
endtask

task automatic load_reg(input logic [3:0] addr, input logic [dw-1:0] val);
   micro_t mi;
   mi   = make_micro(DZ, ADD, RAMF);  // D + 0 into B
   mi.b = addr;
   do_op(mi, val, 1'b1);
endtask

task automatic load_q(input logic [dw-1:0] val);
   do_op(make_micro(DZ, ADD, QREG), val, 1'b1);
endtask

task automatic finish_test(input string name);
   $display("%s: %0d checks, %0d errors", name, t_checks, t_errors);
   t_checks = 0;
   t_errors = 0;
endtask

initial
begin
   micro_t      mi;
   logic [31:0] rnd;
   seed     = 32'h6fbb;
   checks   = 0;
   errors   = 0;
   t_checks = 0;
   t_errors = 0;
   dclo     = 1'b1;
   stb_i    = 1'b0;
   mi_i     = '0;
   d_i      = '0;
   for (int k = 0; k < 16; k++)
      m_regs[k] = '0;
   m_q   = '0;
   m_y   = '0;
   m_psw = '0;
   repeat (3) @(posedge pin_clk);
   @(negedge pin_clk);
   dclo = 1'b0;
   compare_outputs();                 // everything zero out of reset

   for (int k = 0; k < 16; k++)
      load_reg(4'(k), rand_word());
   for (int k = 0; k < n_hold; k++)
      do_op(rand_micro(), rand_word(), 1'b0);  // strobe low, nothing moves
   for (int k = 0; k < 16; k++)
   begin
      mi   = make_micro(ZA, OR, NOP);           // read back register k
      mi.a = 4'(k);
      do_op(mi, rand_word(), 1'b1);
   end
   finish_test("reset and hold");

   for (int k = 0; k < n_arith; k++)
   begin
      rnd = rand32();
      load_reg(rnd[3:0], rand_word());
      load_reg(rnd[7:4], rand_word());
      mi        = make_micro(AB, alu_fn_e'(3'(k % 3)), NOP);
      mi.a      = rnd[3:0];
      mi.b      = rnd[7:4];
      mi.cin    = k[0];               // 2 and 3 coprime, all six pairs
      mi.psw_we = 1'b1;
      do_op(mi, rand_word(), 1'b1);
   end
   finish_test("arithmetic");

   for (int k = 0; k < 64; k++)
   begin
      rnd = rand32();
      load_reg(rnd[3:0], rand_word());
      load_reg(rnd[7:4], rand_word());
      load_q(rand_word());
      mi        = make_micro(alu_src_e'(k[5:3]), alu_fn_e'(k[2:0]), NOP);
      mi.a      = rnd[3:0];
      mi.b      = rnd[7:4];
      mi.cin    = rnd[8];
      mi.psw_we = 1'b1;
      do_op(mi, rand_word(), 1'b1);
   end
   finish_test("sources and functions");

   for (int k = 0; k < 64; k++)
   begin
      rnd = rand32();
      load_reg(rnd[3:0], rand_word());
      load_reg(rnd[7:4], rand_word());
      load_q(rand_word());
      mi        = make_micro(AB, alu_fn_e'(3'(k % 7)), alu_dst_e'(k[5:3]));
      mi.a      = rnd[3:0];
      mi.b      = rnd[7:4];
      mi.sh_in  = k[2];
      mi.cin    = rnd[8];
      mi.psw_we = rnd[9];
      do_op(mi, rand_word(), 1'b1);
      do_op(make_micro(ZQ, OR, NOP), rand_word(), 1'b1);  // Q after shift
      mi   = make_micro(ZB, OR, NOP);
      mi.b = rnd[7:4];
      do_op(mi, rand_word(), 1'b1);
   end
   finish_test("destinations");

   for (int k = 0; k < n_byte; k++)
   begin
      rnd = rand32();
      load_reg(rnd[3:0], rand_word());
      load_reg(rnd[7:4], rand_word());
      mi           = make_micro(AB, alu_fn_e'(3'(k % 8)), NOP);
      mi.a         = rnd[3:0];
      mi.b         = rnd[7:4];
      mi.cin       = rnd[8];
      mi.byte_mode = 1'b1;
      mi.psw_we    = rnd[9];          // status must hold when clear
      do_op(mi, rand_word(), 1'b1);
   end
   finish_test("byte mode and status enable");

   for (int k = 0; k < n_rand; k++)
      do_op(rand_micro(), rand_word(), 1'b1);
   finish_test("random run");

   $display("total: %0d checks, %0d errors", checks, errors);
   if (errors == 0)
      $display("All tests passed!");
   else
      $display("Test failures found");
   $finish;
end

initial
begin
   #((total_ops + 100) * clk_period);
   $display("timeout: the tests did not finish within the expected time");
   $display("Test failures found");
   $finish;
end

endmodule

/* verilog.f */
rtl/am4_pkg.sv
rtl/am4_regfile.sv
rtl/am4_alu.sv
rtl/am4_slice.sv
verif/am4_slice_sva.sv
verif/tb_am4_slice.sv
